// ==== cart_assert.sv ====
`default_nettype none

module cart_assert (
	input wire logic                 clk,
	input wire logic                 rst_n,
	input wire cart_pkg::cart_rsp_t  rsp,
	input wire logic                 rsp_valid,
	input wire logic                 rsp_ready,
	input wire logic                 overflow
);

	// Held response keeps valid and payload
	rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else $error("rsp changed while waiting for rsp_ready");

	// Sticky until reset
	overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		overflow |=> overflow)
		else $error("overflow fell without reset");

	// Nothing pending right after reset
	reset_clear: assert property (@(posedge clk)
		!rst_n |=> !rsp_valid)
		else $error("rsp_valid high in the cycle after reset");

endmodule

bind cart_top cart_assert u_assert (
	.clk       (clk),
	.rst_n     (rst_n),
	.rsp       (rsp),
	.rsp_valid (rsp_valid),
	.rsp_ready (rsp_ready),
	.overflow  (overflow)
);

`default_nettype wire

// ==== cart_bus_decoder.sv ====
`default_nettype none

module cart_bus_decoder (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire cart_pkg::gb_addr_t  a,
	input  wire cart_pkg::gb_data_t  dout,
	input  wire logic                wr,
	input  wire logic                rd,
	input  wire logic                req_ready,
	output cart_pkg::cart_req_t      req,
	output logic                     req_valid,
	output logic                     overflow
);

	// Strobe levels from the previous clock
	logic wr_q;
	logic rd_q;
	logic wr_rise;
	logic rd_rise;
	// Address falls in a range the cartridge answers
	logic hit;
	logic access;
	cart_pkg::cart_region_e region;

	//////////////////////////////////////////////////
	// Strobe edge detect
	//////////////////////////////////////////////////

	// Edge detect history
	always_ff @(posedge clk) begin
		wr_q <= wr;
		rd_q <= rd;
	end

	always_comb begin
		wr_rise = wr & ~wr_q;
		rd_rise = rd & ~rd_q;
		// Write wins if both rise together
		access  = wr_rise | rd_rise;
	end

	//////////////////////////////////////////////////
	// Region classify
	//////////////////////////////////////////////////

	always_comb begin
		region = cart_pkg::REGION_ROM0;
		hit    = 1'b0;
		if (!a[15]) begin
			if (wr_rise) begin
				// MBC registers live below 0x6000
				region = cart_pkg::REGION_CTRL;
				hit    = (a[14:13] != 2'b11);
			end else begin
				region = a[14] ? cart_pkg::REGION_ROMX : cart_pkg::REGION_ROM0;
				hit    = 1'b1;
			end
		end else if (a[15:13] == 3'b101 && !wr_rise) begin
			// External RAM window takes reads only
			region = cart_pkg::REGION_RAM;
			hit    = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Request register
	//////////////////////////////////////////////////

	// One cycle pulse since the bus cannot wait
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_valid <= 1'b0;
			overflow  <= 1'b0;
		end else begin
			req_valid <= access & hit;
			// Request lost when the queue is full
			if (req_valid && !req_ready)
				overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (access && hit) begin
			req.write  <= wr_rise;
			req.region <= region;
			req.addr   <= a;
			req.data   <= dout;
		end
	end

endmodule

`default_nettype wire

// ==== cart_pkg.sv ====
`default_nettype none

package cart_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int ROM_BANK_W    = 9;
	localparam int RAM_BANK_W    = 4;
	// Offset inside a 16 KiB ROM bank
	localparam int ROM_OFFSET_W  = 14;
	// Offset inside an 8 KiB RAM bank
	localparam int RAM_OFFSET_W  = 13;

	// Request queue sizing
	localparam int FIFO_DEPTH    = 4;
	localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W    = $clog2(FIFO_DEPTH + 1);

	// Low nibble that turns external RAM on
	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;

	//////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////

	typedef logic [15:0] gb_addr_t;
	typedef logic [7:0]  gb_data_t;
	typedef logic [ROM_BANK_W-1:0] rom_bank_t;
	typedef logic [RAM_BANK_W-1:0] ram_bank_t;
	typedef logic [ROM_BANK_W+ROM_OFFSET_W-1:0] rom_addr_t;
	typedef logic [RAM_BANK_W+RAM_OFFSET_W-1:0] ram_addr_t;
	// Wide enough for either target, RAM sits in the low bits
	typedef logic [ROM_BANK_W+ROM_OFFSET_W-1:0] mem_addr_t;

	//////////////////////////////////////////////////
	// Enums and structs
	//////////////////////////////////////////////////

	// Kind of cartridge access
	typedef enum logic [1:0] {
		REGION_CTRL = 2'd0,
		REGION_ROM0 = 2'd1,
		REGION_ROMX = 2'd2,
		REGION_RAM  = 2'd3
	} cart_region_e;

	// NONE is a RAM read with RAM disabled
	typedef enum logic [1:0] {
		TARGET_ROM  = 2'd0,
		TARGET_RAM  = 2'd1,
		TARGET_NONE = 2'd2
	} cart_target_e;

	typedef struct packed {
		logic         write;
		cart_region_e region;
		gb_addr_t     addr;
		gb_data_t     data;
	} cart_req_t;

	typedef struct packed {
		cart_target_e target;
		mem_addr_t    addr;
	} cart_rsp_t;

	typedef enum logic {
		MAP_IDLE = 1'b0,
		MAP_RESP = 1'b1
	} mapper_state_e;

endpackage

`default_nettype wire

// ==== cart_req_fifo.sv ====
`default_nettype none

module cart_req_fifo (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire cart_pkg::cart_req_t  in_req,
	input  wire logic                 in_valid,
	input  wire logic                 out_ready,
	output logic                      in_ready,
	output cart_pkg::cart_req_t       out_req,
	output logic                      out_valid
);

	// Entry storage
	cart_pkg::cart_req_t mem [cart_pkg::FIFO_DEPTH];

	logic [cart_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [cart_pkg::FIFO_PTR_W-1:0] rd_ptr;
	// Occupied entries, 0 to FIFO_DEPTH
	logic [cart_pkg::FIFO_CNT_W-1:0] count;
	logic push;
	logic pop;

	// Advance with wrap at the last entry
	function automatic logic [cart_pkg::FIFO_PTR_W-1:0] next_ptr(
		input logic [cart_pkg::FIFO_PTR_W-1:0] ptr
	);
		if (ptr == cart_pkg::FIFO_PTR_W'(cart_pkg::FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	//////////////////////////////////////////////////
	// Flags and head entry
	//////////////////////////////////////////////////

	always_comb begin
		in_ready  = (count != cart_pkg::FIFO_CNT_W'(cart_pkg::FIFO_DEPTH));
		out_valid = (count != '0);
		push      = in_valid & in_ready;
		pop       = out_valid & out_ready;
		out_req   = mem[rd_ptr];
	end

	//////////////////////////////////////////////////
	// Pointers and count
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Push and pop together leave count alone
			unique case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	// Payload write
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_req;
	end

endmodule

`default_nettype wire

// ==== cart_tb.sv ====
`default_nettype none

module cart_tb;

	// About 185 bus accesses of 4 cycles each plus stall and drain headroom
	localparam int MAX_CYCLES = 4000;
	// Reads in flight during the back-pressure test
	localparam int OUTSTANDING_MAX = 3;

	logic clk;
	logic rst_n;
	cart_pkg::gb_addr_t a;
	cart_pkg::gb_data_t dout;
	logic wr;
	logic rd;
	logic rsp_ready;
	cart_pkg::cart_rsp_t rsp;
	logic rsp_valid;
	cart_pkg::rom_bank_t rom_bank;
	logic overflow;

	integer seed;
	int cycles;
	int checks;
	int errors;
	// Error count when the current test started
	int test_errors;
	// Random ready while set and ready_level otherwise
	bit bp_mode;
	logic ready_level;

	// Reference MBC5 registers
	logic m_ram_en;
	cart_pkg::rom_bank_t m_rom_bank;
	cart_pkg::ram_bank_t m_ram_bank;
	// Responses still owed with the oldest first
	cart_pkg::cart_rsp_t exp_q[$];

	cart_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	task automatic model_reset();
		m_ram_en   = 1'b0;
		m_rom_bank = cart_pkg::rom_bank_t'(1);
		m_ram_bank = '0;
	endtask

	// Register picked by the address range
	task automatic model_write(input cart_pkg::gb_addr_t addr,
		input cart_pkg::gb_data_t data);
		if (addr < 16'h2000)
			m_ram_en = (data[3:0] == cart_pkg::RAM_ENABLE_KEY);
		else if (addr < 16'h3000)
			m_rom_bank[7:0] = data;
		else if (addr < 16'h4000)
			m_rom_bank[8] = data[0];
		else if (addr < 16'h6000)
			m_ram_bank = data[3:0];
	endtask

	function automatic cart_pkg::cart_rsp_t model_read(input cart_pkg::gb_addr_t addr);
		cart_pkg::cart_rsp_t r;
		r.target = cart_pkg::TARGET_ROM;
		if (addr < 16'h4000) begin
			// Fixed bank 0
			r.addr = {9'd0, addr[13:0]};
		end else if (addr < 16'h8000) begin
			r.addr = {m_rom_bank, addr[13:0]};
		end else if (m_ram_en) begin
			r.target = cart_pkg::TARGET_RAM;
			r.addr   = {6'd0, m_ram_bank, addr[12:0]};
		end else begin
			r.target = cart_pkg::TARGET_NONE;
			r.addr   = '0;
		end
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Bus driving
	//////////////////////////////////////////////////

	// One clock with ready refreshed on the same edge
	task automatic tick();
		integer r;
		@(posedge clk);
		r = $random(seed);
		rsp_ready <= bp_mode ? r[0] : ready_level;
	endtask

	// Strobe high 2 cycles then low 2 with the model applied as it rises
	task automatic bus_access(input logic write, input cart_pkg::gb_addr_t addr,
		input cart_pkg::gb_data_t data, input bit keep);
		a    <= addr;
		dout <= data;
		wr   <= write;
		rd   <= ~write;
		if (write)
			model_write(addr, data);
		else if (keep)
			exp_q.push_back(model_read(addr));
		repeat (2) tick();
		wr <= 1'b0;
		rd <= 1'b0;
		repeat (2) tick();
	endtask

	task automatic rand_read(input cart_pkg::gb_addr_t base, input cart_pkg::gb_addr_t mask,
		input bit keep);
		integer r;
		r = $random(seed);
		bus_access(1'b0, base | (r[15:0] & mask), r[23:16], keep);
	endtask

	// Extra cycles let writes behind the last read reach the mapper
	task automatic wait_drain();
		while (exp_q.size() != 0)
			tick();
		repeat (3) tick();
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_rsp(input cart_pkg::cart_rsp_t got);
		cart_pkg::cart_rsp_t exp;
		if (exp_q.size() == 0) begin
			errors++;
			$display("Response at %0t arrived with no read outstanding", $time);
		end else begin
			exp = exp_q.pop_front();
			checks++;
			if (got !== exp) begin
				errors++;
				$display("ERROR %0t rsp got %h expected %h", $time, got, exp);
			end
		end
	endtask

	task automatic check_bank(input cart_pkg::rom_bank_t exp);
		checks++;
		if (rom_bank !== exp) begin
			errors++;
			$display("ERROR %0t rom_bank got %h expected %h", $time, rom_bank, exp);
		end
	endtask

	task automatic check_flag(input logic exp);
		checks++;
		if (overflow !== exp) begin
			errors++;
			$display("ERROR %0t overflow got %b expected %b", $time, overflow, exp);
		end
	endtask

	task automatic report_test(input string name);
		if (errors == test_errors)
			$display("%s: PASS", name);
		else
			$display("%s: FAIL, %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// Accepted responses use pre-edge values
	always @(posedge clk) begin
		if (rst_n && rsp_valid && rsp_ready)
			check_rsp(rsp);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		integer r;
		integer r2;
		cart_pkg::gb_data_t d;
		seed = 80;
		cycles = 0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		bp_mode = 1'b0;
		ready_level = 1'b1;
		a = '0;
		dout = '0;
		wr = 1'b0;
		rd = 1'b0;
		rsp_ready = 1'b1;
		rst_n = 1'b0;
		model_reset();
		repeat (5) tick();
		rst_n <= 1'b1;
		tick();

		for (int i = 0; i < 20; i++)
			rand_read(16'h0000, 16'h3FFF, 1'b1);
		wait_drain();
		report_test("Fixed bank reads");

		// Bank 0 forced now and then and bit 8 random
		for (int i = 0; i < 24; i++) begin
			r = $random(seed);
			if (i % 8 == 0) begin
				bus_access(1'b1, 16'h2000, 8'h00, 1'b0);
				bus_access(1'b1, 16'h3000, 8'h00, 1'b0);
			end else begin
				bus_access(1'b1, 16'h2000 | (r[23:8] & 16'h1FFF), r[7:0], 1'b0);
			end
			wait_drain();
			check_bank(m_rom_bank);
			rand_read(16'h4000, 16'h3FFF, 1'b1);
			rand_read(16'h4000, 16'h3FFF, 1'b1);
		end
		wait_drain();
		report_test("ROM bank switching");

		// Still disabled from reset
		rand_read(16'hA000, 16'h1FFF, 1'b1);
		for (int i = 0; i < 10; i++) begin
			r = $random(seed);
			r2 = $random(seed);
			d = r[0] ? {r[7:4], cart_pkg::RAM_ENABLE_KEY} : r[15:8];
			bus_access(1'b1, r2[15:0] & 16'h1FFF, d, 1'b0);
			bus_access(1'b1, 16'h4000 | (r2[31:16] & 16'h1FFF), r[23:16], 1'b0);
			rand_read(16'hA000, 16'h1FFF, 1'b1);
			rand_read(16'hA000, 16'h1FFF, 1'b1);
		end
		wait_drain();
		report_test("RAM enable and banking");

		// Mixed reads under random ready
		bp_mode = 1'b1;
		for (int i = 0; i < 40; i++) begin
			while (exp_q.size() >= OUTSTANDING_MAX)
				tick();
			r = $random(seed);
			case (r[1:0])
				2'd0:    rand_read(16'h0000, 16'h3FFF, 1'b1);
				2'd1:    rand_read(16'h4000, 16'h3FFF, 1'b1);
				default: rand_read(16'hA000, 16'h1FFF, 1'b1);
			endcase
		end
		wait_drain();
		bp_mode = 1'b0;
		check_flag(1'b0);
		report_test("Back-pressure");

		// One read held in the mapper and FIFO_DEPTH queued while the rest drop
		ready_level = 1'b0;
		tick();
		for (int i = 0; i < 8; i++)
			rand_read(16'h4000, 16'h3FFF, i < 1 + cart_pkg::FIFO_DEPTH);
		check_flag(1'b1);
		ready_level = 1'b1;
		wait_drain();
		// Late extra responses would show as unexpected
		repeat (8) tick();
		// Leave the reset bank before reset
		bus_access(1'b1, 16'h2000, 8'hC3, 1'b0);
		check_bank(m_rom_bank);
		rst_n <= 1'b0;
		repeat (5) tick();
		rst_n <= 1'b1;
		tick();
		model_reset();
		check_flag(1'b0);
		check_bank(m_rom_bank);
		report_test("Overflow and reset");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== cart_top.sv ====
`default_nettype none

module cart_top (
	input  wire logic                clk,
	input  wire logic                rst_n,
	// CPU bus
	input  wire cart_pkg::gb_addr_t  a,
	input  wire cart_pkg::gb_data_t  dout,
	input  wire logic                wr,
	input  wire logic                rd,
	// Translated accesses
	output cart_pkg::cart_rsp_t      rsp,
	output logic                     rsp_valid,
	input  wire logic                rsp_ready,
	// Status
	output cart_pkg::rom_bank_t      rom_bank,
	output logic                     overflow
);

	// Decoder to queue
	cart_pkg::cart_req_t req_in;
	logic                req_in_valid;
	logic                req_in_ready;
	// Queue to mapper
	cart_pkg::cart_req_t req_out;
	logic                req_out_valid;
	logic                req_out_ready;

	cart_bus_decoder u_decoder (
		.clk       (clk),
		.rst_n     (rst_n),
		.a         (a),
		.dout      (dout),
		.wr        (wr),
		.rd        (rd),
		.req_ready (req_in_ready),
		.req       (req_in),
		.req_valid (req_in_valid),
		.overflow  (overflow)
	);

	cart_req_fifo u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_req    (req_in),
		.in_valid  (req_in_valid),
		.out_ready (req_out_ready),
		.in_ready  (req_in_ready),
		.out_req   (req_out),
		.out_valid (req_out_valid)
	);

	mbc5_mapper u_mapper (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req_out),
		.req_valid (req_out_valid),
		.rsp_ready (rsp_ready),
		.req_ready (req_out_ready),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.rom_bank  (rom_bank)
	);

endmodule

`default_nettype wire

// ==== flist.f ====
cart_pkg.sv
cart_bus_decoder.sv
cart_req_fifo.sv
mbc5_mapper.sv
cart_top.sv
cart_assert.sv
cart_tb.sv

// ==== mbc5_mapper.sv ====
`default_nettype none

module mbc5_mapper (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire cart_pkg::cart_req_t  req,
	input  wire logic                 req_valid,
	input  wire logic                 rsp_ready,
	output logic                      req_ready,
	output cart_pkg::cart_rsp_t       rsp,
	output logic                      rsp_valid,
	output cart_pkg::rom_bank_t       rom_bank
);

	cart_pkg::mapper_state_e state;

	// Bank registers
	logic                 ram_en;
	cart_pkg::ram_bank_t  ram_bank;

	logic                 take;
	// Bank used for this ROM read
	cart_pkg::rom_bank_t  rd_bank;
	cart_pkg::rom_addr_t  rom_addr;
	cart_pkg::ram_addr_t  ram_addr;
	cart_pkg::cart_rsp_t  rsp_next;

	//////////////////////////////////////////////////
	// Read translation
	//////////////////////////////////////////////////

	always_comb begin
		req_ready = (state == cart_pkg::MAP_IDLE);
		take      = req_valid & req_ready;
		// ROM0 is pinned to bank 0, ROMX may also select 0
		rd_bank   = (req.region == cart_pkg::REGION_ROMX) ? rom_bank : '0;
		rom_addr  = {rd_bank, req.addr[cart_pkg::ROM_OFFSET_W-1:0]};
		ram_addr  = {ram_bank, req.addr[cart_pkg::RAM_OFFSET_W-1:0]};

		rsp_next.target = cart_pkg::TARGET_ROM;
		rsp_next.addr   = rom_addr;
		if (req.region == cart_pkg::REGION_RAM) begin
			if (ram_en) begin
				rsp_next.target = cart_pkg::TARGET_RAM;
				rsp_next.addr   = cart_pkg::mem_addr_t'(ram_addr);
			end else begin
				// Disabled RAM maps nowhere
				rsp_next.target = cart_pkg::TARGET_NONE;
				rsp_next.addr   = '0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Control writes and response FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= cart_pkg::MAP_IDLE;
			ram_en   <= 1'b0;
			rom_bank <= cart_pkg::rom_bank_t'(1);
			ram_bank <= '0;
		end else begin
			unique case (state)
				cart_pkg::MAP_IDLE: begin
					if (take && req.write) begin
						// Register select on A14..A12
						unique case (req.addr[14:12])
							3'b000, 3'b001:
								ram_en <= (req.data[3:0] == cart_pkg::RAM_ENABLE_KEY);
							3'b010:
								rom_bank[7:0] <= req.data;
							3'b011:
								rom_bank[8] <= req.data[0];
							3'b100, 3'b101:
								ram_bank <= req.data[cart_pkg::RAM_BANK_W-1:0];
							default: ;
						endcase
					end else if (take) begin
						state <= cart_pkg::MAP_RESP;
					end
				end
				cart_pkg::MAP_RESP: begin
					// Hold until the sink takes it
					if (rsp_ready)
						state <= cart_pkg::MAP_IDLE;
				end
				default: state <= cart_pkg::MAP_IDLE;
			endcase
		end
	end

	// Response payload, stable while in MAP_RESP
	always_ff @(posedge clk) begin
		if (take && !req.write)
			rsp <= rsp_next;
	end

	assign rsp_valid = (state == cart_pkg::MAP_RESP);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the cartridge testbench with Verilator, run it, judge from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cart_tb -f flist.f -o cart_sim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/cart_sim > sim.log 2>&1
cat sim.log
grep -qx "Test completed successfully" sim.log && echo "Simulation passed" && exit 0 ||
	{ echo "Simulation did not pass"; exit 1; }
